// ==== common/icache_pkg.sv ====
// Shared cache geometry, address field types and controller states; referenced by scoped names
package icache_pkg;

    // ==================================================
    // Address and word
    // ==================================================
    localparam int ADDR_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0]       word_t;

    // ==================================================
    // Geometry of the 4 KB, 2-way cache
    // ==================================================
    localparam int WAYS           = 2;
    localparam int LINE_BYTES     = 32;
    // Four bytes per instruction word
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int SETS           = 64;

    // Field widths of a fetch address
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // ==================================================
    // Address field types
    // ==================================================
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [$clog2(WAYS)-1:0]           way_t;

    // Refill and flush controller states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ADDR,
        CTRL_FILL,
        CTRL_FLUSH
    } ctrl_state_e;

endpackage

// ==== common/icache_fill_if.sv ====
// Refill beat and flush command bundle; the controller drives it, the line store applies it
`timescale 1ns/1ps

interface icache_fill_if;

    // Write strobe for one refill beat
    logic                  fill_we;
    // Set and word slot of the beat
    icache_pkg::index_t    fill_index;
    icache_pkg::word_sel_t fill_word;
    // Memory word and tag of the missed line
    icache_pkg::word_t     fill_data;
    icache_pkg::tag_t      fill_tag;
    // Final beat, commits valid, tag and LRU
    logic                  fill_last;
    // Clear every valid bit
    logic                  flush;

    modport ctrl (
        output fill_we, fill_index, fill_word, fill_data, fill_tag, fill_last, flush
    );

    modport store (
        input fill_we, fill_index, fill_word, fill_data, fill_tag, fill_last, flush
    );

    // Lookup only taps the beat data for forwarding
    modport monitor (
        input fill_data
    );

endinterface

// ==== common/icache_lookup_if.sv ====
// Set read and LRU touch bundle between the lookup logic and the line store
`timescale 1ns/1ps

interface icache_lookup_if;

    // Read address, split from the fetch PC
    icache_pkg::index_t    rd_index;
    icache_pkg::word_sel_t rd_word;

    // Hit update, marks touch_way as most recently used
    logic                  touch;
    icache_pkg::way_t      touch_way;

    // Combinational read data for both ways
    logic [icache_pkg::WAYS-1:0] way_valid;
    icache_pkg::tag_t            way_tag  [icache_pkg::WAYS];
    icache_pkg::word_t           way_data [icache_pkg::WAYS];

    modport lookup (
        output rd_index, rd_word, touch, touch_way,
        input  way_valid, way_tag, way_data
    );

    modport store (
        input  rd_index, rd_word, touch, touch_way,
        output way_valid, way_tag, way_data
    );

endinterface

// ==== icache/icache_ctrl.sv ====
// Miss refill and flush FSM; owns the memory read port and drives line store writes
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Request side
    input  logic                valid_i,
    input  icache_pkg::addr_t   pc_i,
    input  logic                flush_i,
    input  logic                hit_i,
    output logic                ready_o,
    output logic                fwd_o,
    output logic                flush_done_o,
    // Memory read port
    output logic                mem_arvalid_o,
    input  logic                mem_arready_i,
    output icache_pkg::addr_t   mem_araddr_o,
    input  logic                mem_rvalid_i,
    output logic                mem_rready_o,
    input  icache_pkg::word_t   mem_rdata_i,
    // Writes into the line store
    icache_fill_if.ctrl         fill
);

    icache_pkg::ctrl_state_e state_q, state_d;

    // Captured miss, payload only
    icache_pkg::tag_t      miss_tag_q;
    icache_pkg::index_t    miss_index_q;
    icache_pkg::word_sel_t miss_word_q;

    // Word counter for refill beats
    icache_pkg::word_sel_t beat_cnt_q;

    logic miss_start;
    logic beat;
    logic last_beat;

    // ==================================================
    // Handshake decode
    // ==================================================
    // Flush wins over a request seen in idle
    assign ready_o    = (state_q == icache_pkg::CTRL_IDLE) && !flush_i;
    assign miss_start = valid_i && ready_o && !hit_i;

    assign mem_arvalid_o = (state_q == icache_pkg::CTRL_ADDR);
    assign mem_rready_o  = (state_q == icache_pkg::CTRL_FILL);
    // Line aligned request address
    assign mem_araddr_o  = {miss_tag_q, miss_index_q, {icache_pkg::OFFSET_W{1'b0}}};

    assign beat      = mem_rvalid_i && mem_rready_o;
    assign last_beat = (beat_cnt_q == icache_pkg::word_sel_t'(icache_pkg::WORDS_PER_LINE - 1));

    // ==================================================
    // State machine
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::CTRL_IDLE: begin
                if (flush_i) begin
                    state_d = icache_pkg::CTRL_FLUSH;
                end else if (miss_start) begin
                    state_d = icache_pkg::CTRL_ADDR;
                end
            end
            // Hold the address until memory takes it
            icache_pkg::CTRL_ADDR: begin
                if (mem_arready_i) begin
                    state_d = icache_pkg::CTRL_FILL;
                end
            end
            icache_pkg::CTRL_FILL: begin
                if (beat && last_beat) begin
                    state_d = icache_pkg::CTRL_IDLE;
                end
            end
            // Single cycle clear
            icache_pkg::CTRL_FLUSH: begin
                state_d = icache_pkg::CTRL_IDLE;
            end
            default: begin
                state_d = icache_pkg::CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= icache_pkg::CTRL_IDLE;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // Start each refill at word 0
            if (miss_start) begin
                beat_cnt_q <= '0;
            end else if (beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // Fields of the missed fetch
    always_ff @(posedge clk_i) begin
        if (miss_start) begin
            miss_tag_q   <= pc_i[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
            miss_index_q <= pc_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
            miss_word_q  <= pc_i[icache_pkg::OFFSET_W-1:2];
        end
    end

    // ==================================================
    // Line store writes and forwarding
    // ==================================================
    assign fill.fill_we    = beat;
    assign fill.fill_index = miss_index_q;
    assign fill.fill_word  = beat_cnt_q;
    assign fill.fill_data  = mem_rdata_i;
    assign fill.fill_tag   = miss_tag_q;
    assign fill.fill_last  = last_beat;
    assign fill.flush      = (state_q == icache_pkg::CTRL_FLUSH);

    assign flush_done_o = (state_q == icache_pkg::CTRL_FLUSH);
    // Only the requested word goes to the fetch side
    assign fwd_o        = beat && (beat_cnt_q == miss_word_q);

    // Address phase holds its request steady until accepted
    arvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o));

endmodule

// ==== icache/icache_store.sv ====
// Valid, tag, LRU and data arrays of both ways; combinational reads, writes at the clock edge
`timescale 1ns/1ps

module icache_store (
    input  logic          clk_i,
    input  logic          rst_ni,
    icache_fill_if.store  fill,
    icache_lookup_if.store rd
);

    // ==================================================
    // Arrays
    // ==================================================
    // Control bits, cleared by reset
    logic [icache_pkg::SETS-1:0] valid_q [icache_pkg::WAYS];
    // Per set, holds the least recently used way
    logic [icache_pkg::SETS-1:0] lru_q;

    // Payload arrays
    icache_pkg::tag_t  tag_q  [icache_pkg::WAYS][icache_pkg::SETS];
    icache_pkg::word_t data_q [icache_pkg::WAYS][icache_pkg::SETS][icache_pkg::WORDS_PER_LINE];

    // Refill target, stable while the refill runs since no hit touches the LRU
    icache_pkg::way_t victim;

    assign victim = lru_q[fill.fill_index];

    // Combinational read of both ways
    always_comb begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            rd.way_valid[w] = valid_q[w][rd.rd_index];
            rd.way_tag[w]   = tag_q[w][rd.rd_index];
            rd.way_data[w]  = data_q[w][rd.rd_index][rd.rd_word];
        end
    end

    // ==================================================
    // Valid and LRU updates
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (fill.flush) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (fill.fill_we && fill.fill_last) begin
            // Line complete, the other way becomes LRU
            valid_q[victim][fill.fill_index] <= 1'b1;
            lru_q[fill.fill_index]           <= ~victim;
        end else if (rd.touch) begin
            lru_q[rd.rd_index] <= ~rd.touch_way;
        end
    end

    // Data and tag writes of a refill beat
    always_ff @(posedge clk_i) begin
        if (fill.fill_we) begin
            data_q[victim][fill.fill_index][fill.fill_word] <= fill.fill_data;
            if (fill.fill_last) begin
                tag_q[victim][fill.fill_index] <= fill.fill_tag;
            end
        end
    end

    // Hits are only accepted while the controller is idle
    touch_not_in_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(rd.touch && fill.fill_we));

endmodule

// ==== icache/icache_lookup.sv ====
// Tag compare and hit way select; returns hit data or the forwarded refill word
`timescale 1ns/1ps

module icache_lookup (
    input  logic               valid_i,
    input  icache_pkg::addr_t  pc_i,
    input  logic               ready_i,
    input  logic               fwd_i,
    output logic               hit_o,
    output logic               valid_o,
    output icache_pkg::word_t  instruction_o,
    icache_lookup_if.lookup    rd,
    icache_fill_if.monitor     fill
);

    icache_pkg::tag_t            pc_tag;
    logic [icache_pkg::WAYS-1:0] way_hit;
    icache_pkg::way_t            hit_way;
    logic                        any_hit;
    logic                        accept;

    // Split the fetch address
    assign pc_tag      = pc_i[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign rd.rd_index = pc_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign rd.rd_word  = pc_i[icache_pkg::OFFSET_W-1:2];

    // Compare both ways of the set
    always_comb begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            way_hit[w] = rd.way_valid[w] && (rd.way_tag[w] == pc_tag);
        end
    end

    assign any_hit = |way_hit;
    assign hit_way = way_hit[1] ? icache_pkg::way_t'(1) : icache_pkg::way_t'(0);

    // Only a request taken this cycle reports a hit
    assign accept = valid_i && ready_i;

    assign hit_o        = accept && any_hit;
    assign rd.touch     = accept && any_hit;
    assign rd.touch_way = hit_way;

    // Forwarded refill word has hit_o low
    assign valid_o       = (accept && any_hit) || fwd_i;
    assign instruction_o = fwd_i ? fill.fill_data : rd.way_data[hit_way];

    // A line lives in one way only
    always_comb begin
        if (valid_i) begin
            one_way_hit: assert ($onehot0(way_hit))
                else $error("icache_lookup: both ways hit, way_hit=%b", way_hit);
        end
    end

endmodule

// ==== source/icache_top.sv ====
// Instruction cache top level; connects controller, line store and lookup to plain ports
`timescale 1ns/1ps

module icache_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Fetch request and response
    input  icache_pkg::addr_t pc_i,
    input  logic              valid_i,
    output logic              ready_o,
    output icache_pkg::word_t instruction_o,
    output logic              hit_o,
    output logic              valid_o,
    // Memory read port
    output logic              mem_arvalid_o,
    input  logic              mem_arready_i,
    output icache_pkg::addr_t mem_araddr_o,
    input  logic              mem_rvalid_i,
    input  icache_pkg::word_t mem_rdata_i,
    output logic              mem_rready_o,
    // Flush control
    input  logic              flush_i,
    output logic              flush_done_o
);

    logic fwd;

    icache_fill_if   fill_bus ();
    icache_lookup_if lookup_bus ();

    // Refill and flush control
    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .flush_i       (flush_i),
        .hit_i         (hit_o),
        .ready_o       (ready_o),
        .fwd_o         (fwd),
        .flush_done_o  (flush_done_o),
        .mem_arvalid_o (mem_arvalid_o),
        .mem_arready_i (mem_arready_i),
        .mem_araddr_o  (mem_araddr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rready_o  (mem_rready_o),
        .mem_rdata_i   (mem_rdata_i),
        .fill          (fill_bus.ctrl)
    );

    icache_store u_store (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .fill   (fill_bus.store),
        .rd     (lookup_bus.store)
    );

    // Hit path back to the fetch side
    icache_lookup u_lookup (
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .ready_i       (ready_o),
        .fwd_i         (fwd),
        .hit_o         (hit_o),
        .valid_o       (valid_o),
        .instruction_o (instruction_o),
        .rd            (lookup_bus.lookup),
        .fill          (fill_bus.monitor)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset source; 8 ns clock, reset held low for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // Half period of the 8 ns clock
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== testbench/tb_icache_top.sv ====
// Instruction cache testbench; memory model, reference tag model and property checks on the DUT
`timescale 1ns/1ps

module tb_icache_top;

    // ==================================================
    // Constants
    // ==================================================
    localparam logic [31:0] SEED        = 32'h1396979e;
    localparam logic [31:0] MEM_PATTERN = 32'hA5A5_0000;
    localparam int          RAND_REQS   = 24;
    // 14 directed requests plus the random run
    localparam int          NUM_REQS    = 14 + RAND_REQS;
    localparam int          TIMEOUT     = 40 * NUM_REQS + 200;

    logic        clk;
    logic        rst_n;

    // DUT inputs
    logic [31:0] pc_i;
    logic        valid_i;
    logic        mem_arready_i;
    logic        mem_rvalid_i;
    logic [31:0] mem_rdata_i;
    logic        flush_i;

    // DUT outputs
    logic        ready_o;
    logic [31:0] instruction_o;
    logic        hit_o;
    logic        valid_o;
    logic        mem_arvalid_o;
    logic [31:0] mem_araddr_o;
    logic        mem_rready_o;
    logic        flush_done_o;

    // Expected response and the miss being refilled
    logic        exp_hit;
    logic [31:0] miss_pc;

    // Reference copy of valid, tag and LRU state
    logic        model_valid [2][64];
    logic [20:0] model_tag   [2][64];
    logic        model_lru   [64];

    // Event counters, updated on the rising edge
    int unsigned accept_cnt;
    int unsigned fwd_cnt;
    int unsigned flush_done_cnt;
    int unsigned refill_cnt;
    int          mem_beats;
    logic [31:0] mem_base;
    int          cycles = 0;

    logic [31:0] lfsr;
    logic [31:0] rand_addr [RAND_REQS];

    int          prop_errors = 0;
    int          task_errors = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tb_clock_gen clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    icache_top uut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .pc_i          (pc_i),
        .valid_i       (valid_i),
        .ready_o       (ready_o),
        .instruction_o (instruction_o),
        .hit_o         (hit_o),
        .valid_o       (valid_o),
        .mem_arvalid_o (mem_arvalid_o),
        .mem_arready_i (mem_arready_i),
        .mem_araddr_o  (mem_araddr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_rready_o  (mem_rready_o),
        .flush_i       (flush_i),
        .flush_done_o  (flush_done_o)
    );

    // Feedback polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Memory content, word address XOR pattern
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ MEM_PATTERN;
    endfunction

    // ==================================================
    // Memory model
    // ==================================================
    initial begin
        logic [31:0] bits;
        lfsr          = SEED;
        mem_arready_i = 1'b0;
        mem_rvalid_i  = 1'b0;
        mem_rdata_i   = '0;
        // Random fetches: 2 tag bits, 2 index bits, 3 word bits
        for (int i = 0; i < RAND_REQS; i++) begin
            bits         = take_bits(7);
            rand_addr[i] = {19'd0, bits[6:5], 4'd0, bits[4:3], bits[2:0], 2'b00};
        end
        forever begin
            @(negedge clk);
            // Random address accept delay
            if (mem_arvalid_o) begin
                bits          = take_bits(1);
                mem_arready_i = bits[0];
            end else begin
                mem_arready_i = 1'b0;
            end
            // Random gaps between beats
            if (mem_rready_o && mem_beats < 8) begin
                bits         = take_bits(1);
                mem_rvalid_i = bits[0];
            end else begin
                mem_rvalid_i = 1'b0;
            end
            mem_rdata_i = mem_word(mem_base + 32'(4 * mem_beats));
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_cnt     <= 0;
            fwd_cnt        <= 0;
            flush_done_cnt <= 0;
            refill_cnt     <= 0;
            mem_beats      <= 0;
            mem_base       <= '0;
        end else begin
            if (valid_i && ready_o) begin
                accept_cnt <= accept_cnt + 1;
            end
            if (valid_o && !hit_o) begin
                fwd_cnt <= fwd_cnt + 1;
            end
            if (flush_done_o) begin
                flush_done_cnt <= flush_done_cnt + 1;
            end
            if (mem_arvalid_o && mem_arready_i) begin
                refill_cnt <= refill_cnt + 1;
                mem_base   <= mem_araddr_o;
                mem_beats  <= 0;
            end else if (mem_rvalid_i && mem_rready_o) begin
                mem_beats <= mem_beats + 1;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // ==================================================
    // Property checks
    // ==================================================
    reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        ready_o && !mem_arvalid_o && !mem_rready_o && !valid_o && !hit_o && !flush_done_o)
        else begin
            prop_errors++;
            $display("Outputs are not idle after reset");
        end

    hit_decision: assert property (@(posedge clk) disable iff (!rst_n)
        valid_i && ready_o |-> hit_o == exp_hit && valid_o == exp_hit)
        else begin
            prop_errors++;
            $display("MISMATCH hit_o: got %h expected %h at pc_i %h",
                $sampled(hit_o), $sampled(exp_hit), $sampled(pc_i));
        end

    hit_data: assert property (@(posedge clk) disable iff (!rst_n)
        hit_o |-> instruction_o == mem_word(pc_i))
        else begin
            prop_errors++;
            $display("MISMATCH instruction_o: got %h expected %h",
                $sampled(instruction_o), mem_word($sampled(pc_i)));
        end

    // Forwarded word of a miss
    fwd_data: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && !hit_o |-> instruction_o == mem_word(miss_pc))
        else begin
            prop_errors++;
            $display("MISMATCH instruction_o: got %h expected %h",
                $sampled(instruction_o), mem_word($sampled(miss_pc)));
        end

    out_qualified: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> (valid_i && ready_o) || (mem_rvalid_i && mem_rready_o))
        else begin
            prop_errors++;
            $display("valid_o is high without an accepted request or a refill beat");
        end

    busy_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !ready_o |-> !hit_o)
        else begin
            prop_errors++;
            $display("hit_o is high while ready_o is low");
        end

    line_address: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid_o |-> mem_araddr_o == {miss_pc[31:5], 5'd0})
        else begin
            prop_errors++;
            $display("MISMATCH mem_araddr_o: got %h expected %h",
                $sampled(mem_araddr_o), {$sampled(miss_pc[31:5]), 5'd0});
        end

    // Refill ends after exactly eight beats
    beat_count: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_rready_o) |-> mem_beats == 8)
        else begin
            prop_errors++;
            $display("MISMATCH refill beats: got %h expected %h", $sampled(mem_beats), 8);
        end

    flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        flush_done_o |=> !flush_done_o)
        else begin
            prop_errors++;
            $display("flush_done_o stayed high for more than one cycle");
        end

    flush_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_i || flush_done_o) |-> !ready_o)
        else begin
            prop_errors++;
            $display("ready_o is high during a flush");
        end

    // ==================================================
    // Reference model and stimulus
    // ==================================================
    function automatic logic predict_hit(input logic [31:0] addr);
        logic [5:0] set;
        set = addr[10:5];
        return (model_valid[0][set] && model_tag[0][set] == addr[31:11])
            || (model_valid[1][set] && model_tag[1][set] == addr[31:11]);
    endfunction

    // Hit makes its way MRU, a miss fills the LRU way
    task automatic update_model(input logic [31:0] addr, input logic hit);
        logic [5:0] set;
        logic       way;
        set = addr[10:5];
        if (hit) begin
            way = model_valid[1][set] && model_tag[1][set] == addr[31:11];
        end else begin
            way                   = model_lru[set];
            model_valid[way][set] = 1'b1;
            model_tag[way][set]   = addr[31:11];
        end
        model_lru[set] = !way;
    endtask

    task automatic fetch(input logic [31:0] addr);
        int unsigned accepts_before;
        int unsigned exp_refills;
        int unsigned exp_fwd;
        logic        hit_pred;
        hit_pred       = predict_hit(addr);
        accepts_before = accept_cnt;
        // One line read per miss, none for a hit or a request held while busy
        exp_refills    = hit_pred ? refill_cnt : refill_cnt + 1;
        exp_fwd        = hit_pred ? fwd_cnt : fwd_cnt + 1;
        exp_hit        = hit_pred;
        if (!hit_pred) begin
            miss_pc = addr;
        end
        pc_i    = addr;
        valid_i = 1'b1;
        @(negedge clk);
        while (accept_cnt == accepts_before) begin
            @(negedge clk);
        end
        update_model(addr, hit_pred);
        // Request stays on the bus until the refill ends
        while (!ready_o) begin
            @(negedge clk);
        end
        valid_i = 1'b0;
        assert (refill_cnt == exp_refills) else begin
            task_errors++;
            $display("MISMATCH memory read requests: got %h expected %h",
                refill_cnt, exp_refills);
        end
        assert (fwd_cnt == exp_fwd) else begin
            task_errors++;
            $display("MISMATCH forwarded words: got %h expected %h", fwd_cnt, exp_fwd);
        end
    endtask

    task automatic flush_cache();
        int unsigned done_before;
        done_before = flush_done_cnt;
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        while (!ready_o) begin
            @(negedge clk);
        end
        for (int s = 0; s < 64; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
        end
        assert (flush_done_cnt == done_before + 1) else begin
            task_errors++;
            $display("MISMATCH flush_done_o pulses: got %h expected %h",
                flush_done_cnt - done_before, 1);
        end
    endtask

    task automatic finish_test(input string name);
        int total;
        total = prop_errors + task_errors;
        if (total == errors_at_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, total - errors_at_start);
        end
        errors_at_start = total;
    endtask

    initial begin
        pc_i    = '0;
        valid_i = 1'b0;
        flush_i = 1'b0;
        exp_hit = 1'b0;
        miss_pc = '0;
        for (int s = 0; s < 64; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_tag[0][s]   = '0;
            model_tag[1][s]   = '0;
            model_lru[s]      = 1'b0;
        end
        @(posedge rst_n);
        @(negedge clk);
        finish_test("reset state");

        fetch(32'h0000_1044);
        finish_test("cold miss");

        fetch(32'h0000_1040);
        fetch(32'h0000_105C);
        fetch(32'h0000_1044);
        fetch(32'h0000_1050);
        finish_test("repeat fetches");

        // Set 5, tags A, B, A, C then A hits and B misses
        fetch(32'h0001_00A0);
        fetch(32'h0002_00A4);
        fetch(32'h0001_00A8);
        fetch(32'h0003_00B0);
        fetch(32'h0001_00BC);
        fetch(32'h0002_00A4);
        finish_test("LRU replacement");

        // All three resident lines miss again
        flush_cache();
        fetch(32'h0000_1044);
        fetch(32'h0001_00A0);
        fetch(32'h0002_00A4);
        finish_test("flush");

        for (int i = 0; i < RAND_REQS; i++) begin
            fetch(rand_addr[i]);
        end
        finish_test("random memory delays");

        repeat (4) @(negedge clk);
        $display("Tests passed %0d, failed %0d, errors %0d",
            tests_passed, tests_failed, prop_errors + task_errors);
        if (tests_failed == 0 && prop_errors + task_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/icache_pkg.sv
common/icache_fill_if.sv
common/icache_lookup_if.sv
icache/icache_ctrl.sv
icache/icache_store.sv
icache/icache_lookup.sv
source/icache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_icache_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_icache_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
